/* tcb_converter_top.f */
source/tcb_pkg.sv
source/tcb_ctrl.sv
source/tcb_lane_align.sv
source/tcb_lane_gather.sv
source/tcb_sram.sv
source/tcb_converter_top.sv
bench/tcb_converter_asserts.sv
bench/tcb_converter_tb.sv

/* bench/tcb_converter_tb.sv */
// drives the converter top level with a directed table and random accesses checked against a byte model

`timescale 1ns/1ps

module tcb_converter_tb
  import tcb_pkg::*;
#(
  parameter int unsigned DAW = 10
);

  // table length, random count and cycle limit
  localparam int unsigned NROWS = 22;
  localparam int unsigned NRND  = 40;
  localparam int unsigned LIMIT = (NROWS + NRND) * 4 + 50;
  // random window of four words
  localparam logic [DAW-1:0] RND_BASE = 'h100;
  // table shorthands
  localparam logic RD = 1'b0;
  localparam logic WR = 1'b1;
  localparam logic LE = 1'b0;
  localparam logic BE = 1'b1;

  typedef struct packed {
    logic           wen;
    logic           ndn;
    tcb_siz_t       siz;
    logic [DAW-1:0] adr;
    tcb_data_t      wdt;
    tcb_data_t      rdt;
    tcb_sts_t       sts;
  } row_t;

  // outstanding response
  typedef struct packed {
    logic [31:0] due;
    logic        chk;
    tcb_data_t   rdt;
    tcb_sts_t    sts;
  } exp_t;

  logic           clk;
  logic           arst_n;
  logic           vld;
  logic           rdy;
  logic           wen;
  logic           ndn;
  tcb_siz_t       siz;
  logic [DAW-1:0] adr;
  tcb_data_t      wdt;
  logic           rsp_vld;
  tcb_data_t      rdt;
  tcb_sts_t       sts;

  row_t        rows [NROWS];
  int unsigned n_rows;
  exp_t        exp_q [$];
  logic [7:0]  model [2**DAW];
  int unsigned cycles;
  int unsigned err_cnt;
  int unsigned rsp_cnt;
  int unsigned n_pass;
  int unsigned n_fail;
  integer      seed;

  tcb_converter_top #(
    .DAW (DAW)
  ) dut_i (
    .clk     (clk),
    .arst_n  (arst_n),
    .vld     (vld),
    .rdy     (rdy),
    .wen     (wen),
    .ndn     (ndn),
    .siz     (siz),
    .adr     (adr),
    .wdt     (wdt),
    .rsp_vld (rsp_vld),
    .rdt     (rdt),
    .sts     (sts)
  );

  ////////////////////////////////////////
  // clock and cycle limit
  ////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    cycles = 0;
    while (cycles < LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("run timed out after %0d cycles", cycles);
    $display("Simulation failed");
    $finish;
  end

  ////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////

  task automatic check_rdt(input tcb_data_t got, input tcb_data_t exp, input int unsigned idx);
    if (got !== exp) begin
      $display("Error: rdt = 0x%08h, expected 0x%08h (response %0d)", got, exp, idx);
      err_cnt++;
    end
  endtask

  task automatic check_sts(input tcb_sts_t got, input tcb_sts_t exp, input int unsigned idx);
    if (got !== exp) begin
      $display("Error: sts = 0x%0h, expected 0x%0h (response %0d)", got, exp, idx);
      err_cnt++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Error: %s = 0x%0h, expected 0x%0h at cycle %0d", name, got, exp, cycles);
      err_cnt++;
    end
  endtask

  ////////////////////////////////////////
  // response monitor
  ////////////////////////////////////////

  // sampled mid cycle once outputs have settled
  always @(negedge clk) begin
    exp_t e;
    if (rsp_vld === 1'b1) begin
      if (exp_q.size() == 0) begin
        $display("Error: response arrived with no request outstanding at cycle %0d", cycles);
        err_cnt++;
      end else begin
        e = exp_q.pop_front();
        rsp_cnt++;
        if (e.due != cycles) begin
          $display("Error: response came at cycle %0d instead of cycle %0d", cycles, e.due);
          err_cnt++;
        end
        check_sts(sts, e.sts, rsp_cnt);
        if (e.chk) begin
          check_rdt(rdt, e.rdt, rsp_cnt);
        end
      end
    end else if (exp_q.size() != 0 && exp_q[0].due <= cycles) begin
      $display("Error: no response came for the request due at cycle %0d", exp_q[0].due);
      void'(exp_q.pop_front());
      err_cnt++;
    end
  end

  ////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////

  // called 1 ns after an edge and returns 1 ns after the accepting edge
  task automatic send(input logic w, input logic n, input tcb_siz_t s, input logic [DAW-1:0] a,
                      input tcb_data_t d, input logic chk, input tcb_data_t exp_rdt,
                      input tcb_sts_t exp_sts);
    exp_t e;
    vld = 1'b1;
    wen = w;
    ndn = n;
    siz = s;
    adr = a;
    wdt = d;
    while (rdy !== 1'b1) begin
      @(posedge clk);
      #1;
    end
    // response due on the cycle after the accepting edge
    e.due = cycles + 1;
    e.chk = chk;
    e.rdt = exp_rdt;
    e.sts = exp_sts;
    exp_q.push_back(e);
    @(posedge clk);
    #1;
    vld = 1'b0;
  endtask

  task automatic idle(input int unsigned n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic drain();
    while (exp_q.size() != 0) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic report(input string name, input int unsigned err_before);
    if (err_cnt == err_before) begin
      $display("test %s: pass", name);
      n_pass++;
    end else begin
      $display("test %s: FAIL with %0d errors", name, err_cnt - err_before);
      n_fail++;
    end
  endtask

  ////////////////////////////////////////
  // byte model
  ////////////////////////////////////////

  // address of reference byte k
  // little endian gives adr + k and big endian adr + size - 1 - k
  function automatic logic [DAW-1:0] byte_addr(input logic [DAW-1:0] a, input tcb_siz_t s,
                                               input logic n, input int k);
    int unsigned pos;
    if (n) begin
      pos = (1 << s) - 1 - k;
    end else begin
      pos = k;
    end
    return a + pos[DAW-1:0];
  endfunction

  task automatic model_write(input logic [DAW-1:0] a, input tcb_siz_t s, input logic n,
                             input tcb_data_t d);
    for (int k = 0; k < (1 << s); k++) begin
      model[byte_addr(a, s, n, k)] = d[8*k +: 8];
    end
  endtask

  // bytes above the size stay zero
  function automatic tcb_data_t model_read(input logic [DAW-1:0] a, input tcb_siz_t s,
                                           input logic n);
    tcb_data_t r;
    r = '0;
    for (int k = 0; k < (1 << s); k++) begin
      r[8*k +: 8] = model[byte_addr(a, s, n, k)];
    end
    return r;
  endfunction

  ////////////////////////////////////////
  // directed table
  ////////////////////////////////////////

  task automatic add_row(input logic w, input logic n, input tcb_siz_t s, input logic [DAW-1:0] a,
                         input tcb_data_t d, input tcb_data_t r, input tcb_sts_t st);
    if (n_rows < NROWS) begin
      rows[n_rows] = '{w, n, s, a, d, r, st};
    end
    n_rows++;
  endtask

  task automatic load_table();
    // little word write followed by every aligned byte and half
    add_row(WR, LE, TCB_SIZ_4, 'h010, 32'h44332211, 32'h0, TCB_STS_OK);
    add_row(RD, LE, TCB_SIZ_1, 'h010, 32'h0, 32'h00000011, TCB_STS_OK);
    add_row(RD, LE, TCB_SIZ_1, 'h011, 32'h0, 32'h00000022, TCB_STS_OK);
    add_row(RD, LE, TCB_SIZ_1, 'h012, 32'h0, 32'h00000033, TCB_STS_OK);
    add_row(RD, LE, TCB_SIZ_1, 'h013, 32'h0, 32'h00000044, TCB_STS_OK);
    add_row(RD, LE, TCB_SIZ_2, 'h010, 32'h0, 32'h00002211, TCB_STS_OK);
    add_row(RD, LE, TCB_SIZ_2, 'h012, 32'h0, 32'h00004433, TCB_STS_OK);
    add_row(RD, LE, TCB_SIZ_4, 'h010, 32'h0, 32'h44332211, TCB_STS_OK);
    // big half swaps the two bytes
    add_row(RD, BE, TCB_SIZ_2, 'h010, 32'h0, 32'h00001122, TCB_STS_OK);
    // big halves whose upper data bytes must be ignored
    add_row(WR, BE, TCB_SIZ_2, 'h020, 32'h9999bbaa, 32'h0, TCB_STS_OK);
    add_row(WR, BE, TCB_SIZ_2, 'h022, 32'h7777ddcc, 32'h0, TCB_STS_OK);
    add_row(RD, LE, TCB_SIZ_4, 'h020, 32'h0, 32'hccddaabb, TCB_STS_OK);
    // big word with the most significant byte at the lowest address
    add_row(WR, BE, TCB_SIZ_4, 'h030, 32'h01020304, 32'h0, TCB_STS_OK);
    add_row(RD, LE, TCB_SIZ_4, 'h030, 32'h0, 32'h04030201, TCB_STS_OK);
    add_row(WR, BE, TCB_SIZ_1, 'h035, 32'ha5a5a55a, 32'h0, TCB_STS_OK);
    add_row(RD, LE, TCB_SIZ_1, 'h035, 32'h0, 32'h0000005a, TCB_STS_OK);
    add_row(RD, BE, TCB_SIZ_4, 'h030, 32'h0, 32'h01020304, TCB_STS_OK);
    // misaligned accesses leave word 0x010 unchanged
    add_row(WR, LE, TCB_SIZ_2, 'h011, 32'h0000ffff, 32'h0, TCB_STS_MAL);
    add_row(WR, LE, TCB_SIZ_4, 'h012, 32'hffffffff, 32'h0, TCB_STS_MAL);
    add_row(RD, LE, TCB_SIZ_4, 'h011, 32'h0, 32'h0, TCB_STS_MAL);
    add_row(RD, BE, TCB_SIZ_2, 'h013, 32'h0, 32'h0, TCB_STS_MAL);
    add_row(RD, LE, TCB_SIZ_4, 'h010, 32'h0, 32'h44332211, TCB_STS_OK);
  endtask

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////

  initial begin
    row_t           r;
    logic [DAW-1:0] a;
    tcb_siz_t       s;
    logic           w;
    logic           n;
    tcb_data_t      d;
    int unsigned    off;
    int unsigned    base_err;

    seed    = 75;
    err_cnt = 0;
    rsp_cnt = 0;
    n_pass  = 0;
    n_fail  = 0;
    n_rows  = 0;
    arst_n  = 1'b0;
    vld     = 1'b0;
    wen     = 1'b0;
    ndn     = 1'b0;
    siz     = TCB_SIZ_1;
    adr     = '0;
    wdt     = '0;
    load_table();

    // quiet outputs in reset and rdy up one clock after release
    base_err = err_cnt;
    repeat (2) @(posedge clk);
    #1;
    check_flag("rdy", rdy, 1'b0);
    check_flag("rsp_vld", rsp_vld, 1'b0);
    arst_n = 1'b1;
    #1;
    // no clock edge since release yet
    check_flag("rdy", rdy, 1'b0);
    @(posedge clk);
    #1;
    check_flag("rdy", rdy, 1'b1);
    check_flag("rsp_vld", rsp_vld, 1'b0);
    report("reset", base_err);

    // table rows back to back with one transfer per cycle
    base_err = err_cnt;
    if (n_rows != NROWS) begin
      $display("table holds %0d rows instead of %0d", n_rows, NROWS);
      err_cnt++;
    end
    for (int i = 0; i < NROWS; i++) begin
      r = rows[i];
      send(r.wen, r.ndn, r.siz, r.adr, r.wdt, !r.wen || r.sts, r.rdt, r.sts);
    end
    drain();
    report("table", base_err);

    // random phase where the first four word writes fill the window
    base_err = err_cnt;
    for (int i = 0; i < NRND; i++) begin
      n = $random(seed);
      d = $random(seed);
      if (i < 4) begin
        w = WR;
        s = TCB_SIZ_4;
        a = RND_BASE + 4 * i;
      end else begin
        w   = $random(seed);
        s   = tcb_siz_t'({$random(seed)} % 3);
        off = {$random(seed)} % 16;
        off = off & ~((1 << s) - 1);
        a   = RND_BASE + off[DAW-1:0];
      end
      // occasional gap between transfers
      if ({$random(seed)} % 4 == 0) begin
        idle(1);
      end
      if (w) begin
        model_write(a, s, n, d);
        send(w, n, s, a, d, 1'b0, '0, TCB_STS_OK);
      end else begin
        send(w, n, s, a, d, 1'b1, model_read(a, s, n), TCB_STS_OK);
      end
    end
    drain();
    report("random", base_err);

    $display("tests passed %0d, failed %0d, errors %0d", n_pass, n_fail, err_cnt);
    if (n_fail == 0 && err_cnt == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* bench/tcb_converter_asserts.sv */
// handshake and response timing checks, bound into every converter top level

`timescale 1ns/1ps

module tcb_converter_asserts
  import tcb_pkg::*;
(
  input logic     clk,
  input logic     arst_n,
  input logic     vld,
  input logic     rdy,
  input logic     rsp_vld,
  input tcb_sts_t sts
);

  // transfer on both handshake lines
  logic trn;

  assign trn = vld & rdy;

  ////////////////////////////////////////
  // response timing
  ////////////////////////////////////////

  // exactly one cycle from transfer to response
  rsp_after_trn: assert property (
    @(posedge clk) disable iff (!arst_n) trn |=> rsp_vld
  ) else $error("rsp_vld missing one cycle after a transfer");

  rsp_only_after_trn: assert property (
    @(posedge clk) disable iff (!arst_n) !trn |=> !rsp_vld
  ) else $error("rsp_vld high without a transfer in the cycle before");

  ////////////////////////////////////////
  // reset and status
  ////////////////////////////////////////

  // handshake quiet while in reset
  quiet_in_reset: assert property (
    @(posedge clk) !arst_n |-> (!rdy && !rsp_vld)
  ) else $error("rdy or rsp_vld high during reset");

  // status only travels with a response
  sts_with_rsp: assert property (
    @(posedge clk) sts |-> rsp_vld
  ) else $error("sts high without rsp_vld");

endmodule

// attach to the converter top level
bind tcb_converter_top tcb_converter_asserts asserts_i (
  .clk     (clk),
  .arst_n  (arst_n),
  .vld     (vld),
  .rdy     (rdy),
  .rsp_vld (rsp_vld),
  .sts     (sts)
);

/* source/tcb_converter_top.sv */
// converter top level: control, lane steering and on-chip memory wired together

`timescale 1ns/1ps

module tcb_converter_top
  import tcb_pkg::*;
#(
  // byte address width
  parameter int unsigned DAW = 10
)(
  input  logic           clk,
  input  logic           arst_n,
  // request
  input  logic           vld,
  output logic           rdy,
  input  logic           wen,
  input  logic           ndn,
  input  tcb_siz_t       siz,
  input  logic [DAW-1:0] adr,
  input  tcb_data_t      wdt,
  // response
  output logic           rsp_vld,
  output tcb_data_t      rdt,
  output tcb_sts_t       sts
);

  ////////////////////////////////////////
  // internal wires
  ////////////////////////////////////////

  // request stage
  tcb_ben_t               ref_ben;
  logic                   mem_ena;
  logic                   mem_wen;
  logic [DAW-TCB_OFW-1:0] mem_adr;
  tcb_data_t              lane_wdt;
  tcb_ben_t               lane_ben;

  // response stage
  tcb_data_t              lane_rdt;
  tcb_off_t               rsp_off;
  tcb_siz_t               rsp_siz;
  logic                   rsp_ndn;

  ////////////////////////////////////////
  // instances
  ////////////////////////////////////////

  // handshake, checks, response register
  tcb_ctrl #(
    .DAW (DAW)
  ) ctrl_i (
    .clk     (clk),
    .arst_n  (arst_n),
    .vld     (vld),
    .rdy     (rdy),
    .wen     (wen),
    .ndn     (ndn),
    .siz     (siz),
    .adr     (adr),
    .ref_ben (ref_ben),
    .mem_ena (mem_ena),
    .mem_wen (mem_wen),
    .mem_adr (mem_adr),
    .rsp_vld (rsp_vld),
    .rsp_off (rsp_off),
    .rsp_siz (rsp_siz),
    .rsp_ndn (rsp_ndn),
    .sts     (sts)
  );

  // write steering, offset straight from the low address bits
  tcb_lane_align align_i (
    .wdt      (wdt),
    .ref_ben  (ref_ben),
    .off      (adr[TCB_OFW-1:0]),
    .siz      (siz),
    .ndn      (ndn),
    .lane_wdt (lane_wdt),
    .lane_ben (lane_ben)
  );

  // memory
  tcb_sram #(
    .DAW (DAW)
  ) sram_i (
    .clk (clk),
    .ena (mem_ena),
    .wen (mem_wen),
    .adr (mem_adr),
    .ben (lane_ben),
    .wdt (lane_wdt),
    .rdt (lane_rdt)
  );

  // read steering in the response cycle
  tcb_lane_gather gather_i (
    .lane_rdt (lane_rdt),
    .off      (rsp_off),
    .siz      (rsp_siz),
    .ndn      (rsp_ndn),
    .sts      (sts),
    .rdt      (rdt)
  );

endmodule

/* source/tcb_sram.sv */
// byte-enabled synchronous word memory, read data valid one cycle after enable

`timescale 1ns/1ps

module tcb_sram
  import tcb_pkg::*;
#(
  // byte address width
  parameter int unsigned DAW = 10
)(
  input  logic                   clk,
  // strobes
  input  logic                   ena,
  input  logic                   wen,
  // word address
  input  logic [DAW-TCB_OFW-1:0] adr,
  // write side
  input  tcb_ben_t               ben,
  input  tcb_data_t              wdt,
  // read side
  output tcb_data_t              rdt
);

  // words in the array
  localparam int unsigned DEPTH = (2 ** DAW) / TCB_BEW;

  // storage, byte addressable per word
  logic [TCB_BEW-1:0][7:0] mem [DEPTH];

  // write data byte view
  logic [TCB_BEW-1:0][7:0] wdt_byte;

  assign wdt_byte = wdt;

  // write enabled bytes only, otherwise register the read word
  always_ff @(posedge clk) begin
    if (ena) begin
      if (wen) begin
        for (int i = 0; i < TCB_BEW; i++) begin
          if (ben[i]) mem[adr][i] <= wdt_byte[i];
        end
      end else begin
        rdt <= mem[adr];
      end
    end
  end

endmodule

/* source/tcb_lane_gather.sv */
// memory to reference steering of read data with size and status masking, purely combinational

`timescale 1ns/1ps

module tcb_lane_gather
  import tcb_pkg::*;
(
  // registered memory word
  input  tcb_data_t lane_rdt,
  // response attributes
  input  tcb_off_t  off,
  input  tcb_siz_t  siz,
  input  logic      ndn,
  input  tcb_sts_t  sts,
  // reference layout, data in low bytes
  output tcb_data_t rdt
);

  // byte views
  logic [TCB_BEW-1:0][7:0] lane_byte;
  logic [TCB_BEW-1:0][7:0] ref_byte;

  // last reference byte index
  tcb_off_t lst;

  assign lane_byte = lane_rdt;
  assign lst       = tcb_off_t'((3'd1 << siz) - 3'd1);

  ////////////////////////////////////////
  // inverse lane mapping
  ////////////////////////////////////////

  // reference byte k comes back from the lane it was written to
  always_comb begin
    tcb_off_t sel;
    for (int k = 0; k < TCB_BEW; k++) begin
      if (ndn) begin
        sel = off + lst - tcb_off_t'(k);
      end else begin
        sel = off + tcb_off_t'(k);
      end
      // bytes beyond the access size read as zero
      if (k <= int'(lst)) begin
        ref_byte[k] = lane_byte[sel];
      end else begin
        ref_byte[k] = 8'h00;
      end
    end
  end

  // misaligned response returns an empty word
  assign rdt = (sts == TCB_STS_MAL) ? '0 : tcb_data_t'(ref_byte);

endmodule

/* source/tcb_lane_align.sv */
// reference to memory steering of write data and byte enables, purely combinational

`timescale 1ns/1ps

module tcb_lane_align
  import tcb_pkg::*;
(
  // reference layout, data in low bytes
  input  tcb_data_t wdt,
  input  tcb_ben_t  ref_ben,
  // access attributes
  input  tcb_off_t  off,
  input  tcb_siz_t  siz,
  input  logic      ndn,
  // memory layout, one byte per address lane
  output tcb_data_t lane_wdt,
  output tcb_ben_t  lane_ben
);

  // byte views of the data words
  logic [TCB_BEW-1:0][7:0] ref_byte;
  logic [TCB_BEW-1:0][7:0] lane_byte;

  // last reference byte index, size minus one
  tcb_off_t lst;

  assign ref_byte = wdt;
  assign lst      = tcb_off_t'((3'd1 << siz) - 3'd1);

  ////////////////////////////////////////
  // per lane select
  ////////////////////////////////////////

  // lane i takes reference byte k
  //   little: lane = off + k       -> k = i - off
  //   big:    lane = off + lst - k -> k = off + lst - i
  // wrap-around modulo word size comes from the 2-bit type
  always_comb begin
    tcb_off_t sel;
    for (int i = 0; i < TCB_BEW; i++) begin
      if (ndn) begin
        sel = off + lst - tcb_off_t'(i);
      end else begin
        sel = tcb_off_t'(i) - off;
      end
      lane_byte[i] = ref_byte[sel];
      // unused reference bytes carry no enable, so lanes stay quiet
      lane_ben[i]  = ref_ben[sel];
    end
  end

  assign lane_wdt = lane_byte;

endmodule

/* source/tcb_ctrl.sv */
// converter control: handshake, misalignment check, byte-enable decode and response register

`timescale 1ns/1ps

module tcb_ctrl
  import tcb_pkg::*;
#(
  // byte address width
  parameter int unsigned DAW = 10
)(
  input  logic                 clk,
  input  logic                 arst_n,
  // request handshake
  input  logic                 vld,
  output logic                 rdy,
  // request attributes
  input  logic                 wen,
  input  logic                 ndn,
  input  tcb_siz_t             siz,
  input  logic [DAW-1:0]       adr,
  // reference byte enables, low aligned
  output tcb_ben_t             ref_ben,
  // memory strobes
  output logic                 mem_ena,
  output logic                 mem_wen,
  output logic [DAW-TCB_OFW-1:0] mem_adr,
  // response stage
  output logic                 rsp_vld,
  output tcb_off_t             rsp_off,
  output tcb_siz_t             rsp_siz,
  output logic                 rsp_ndn,
  output tcb_sts_t             sts
);

  // transfer and misalignment flags
  logic     trn;
  logic     mal;
  tcb_off_t off;

  ////////////////////////////////////////
  // request stage
  ////////////////////////////////////////

  // ready comes up one clock after reset release, memory never stalls
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rdy <= 1'b0;
    end else begin
      rdy <= 1'b1;
    end
  end

  // handshake completes on both high
  assign trn = vld & rdy;

  // byte offset inside the word
  assign off = adr[TCB_OFW-1:0];

  // address must be a multiple of the size
  always_comb begin
    case (siz)
      TCB_SIZ_1: mal = 1'b0;
      TCB_SIZ_2: mal = off[0];
      TCB_SIZ_4: mal = |off;
      // size code 3 not supported, reported as misaligned
      default:   mal = 1'b1;
    endcase
  end

  // low aligned enables from size
  always_comb begin
    case (siz)
      TCB_SIZ_1: ref_ben = 4'b0001;
      TCB_SIZ_2: ref_ben = 4'b0011;
      TCB_SIZ_4: ref_ben = 4'b1111;
      default:   ref_ben = 4'b0000;
    endcase
  end

  // misaligned accesses never touch memory
  assign mem_ena = trn & ~mal;
  assign mem_wen = wen;
  // word address
  assign mem_adr = adr[DAW-1:TCB_OFW];

  ////////////////////////////////////////
  // response stage
  ////////////////////////////////////////

  // valid and status, one cycle after transfer
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rsp_vld <= 1'b0;
      sts     <= TCB_STS_OK;
    end else begin
      rsp_vld <= trn;
      sts     <= (trn && mal) ? TCB_STS_MAL : TCB_STS_OK;
    end
  end

  // attributes for the gather stage
  always_ff @(posedge clk) begin
    if (trn) begin
      rsp_off <= off;
      rsp_siz <= siz;
      rsp_ndn <= ndn;
    end
  end

endmodule

/* source/tcb_pkg.sv */
// shared bus widths, size and status encodings, and data types; imported by every RTL file

package tcb_pkg;

  ////////////////////////////////////////
  // bus geometry
  ////////////////////////////////////////

  // bytes per data word
  localparam int unsigned TCB_BEW = 4;
  // data width in bits
  localparam int unsigned TCB_DW = 8 * TCB_BEW;
  // width of the byte offset inside a word
  localparam int unsigned TCB_OFW = $clog2(TCB_BEW);

  ////////////////////////////////////////
  // types
  ////////////////////////////////////////

  // one data word
  typedef logic [TCB_DW-1:0] tcb_data_t;
  // byte enables, one bit per lane
  typedef logic [TCB_BEW-1:0] tcb_ben_t;
  // log2 of access size in bytes
  typedef logic [1:0] tcb_siz_t;
  // byte offset within a word (low address bits)
  typedef logic [TCB_OFW-1:0] tcb_off_t;
  // response status
  typedef logic tcb_sts_t;

  ////////////////////////////////////////
  // encodings
  ////////////////////////////////////////

  // size codes: 1, 2 and 4 bytes
  localparam tcb_siz_t TCB_SIZ_1 = 2'd0;
  localparam tcb_siz_t TCB_SIZ_2 = 2'd1;
  localparam tcb_siz_t TCB_SIZ_4 = 2'd2;

  // status codes
  localparam tcb_sts_t TCB_STS_OK  = 1'b0;
  localparam tcb_sts_t TCB_STS_MAL = 1'b1;

endpackage
